//--- sim.f
+incdir+hdl
+incdir+sim
hdl/csr_pkg.sv
hdl/csr_issue.sv
hdl/csr_regfile.sv
hdl/csr_timer.sv
hdl/csr_top.sv
sim/tb_clkgen.sv
sim/tb_csr.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module tb_csr -f sim.f -o tb_csr_sim \
    > build.log 2>&1 &&
./obj_dir/tb_csr_sim > sim.log 2>&1 ||
{ cat build.log; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Verification failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

//--- sim/tb_csr_tasks.svh
task automatic test_reset();
    logic [31:0] d;
    int          start;
    start = errors;
    read_csr(`CSR_ADDR_CRMD, d);
    check_word("crmd", d, 32'h8);
    read_csr(`CSR_ADDR_PRMD, d);
    check_word("prmd", d, 32'h0);
    read_csr(`CSR_ADDR_ERA, d);
    check_word("era", d, 32'h0);
    read_csr(`CSR_ADDR_SAVE0, d);
    check_word("save0", d, 32'h0);
    read_csr(`CSR_ADDR_EENTRY, d);
    check_word("eentry", d, 32'h0);
    check_word("crmd port", {23'b0, crmd}, 32'h8);
    end_test("reset values", start);
endtask

task automatic test_masked_writes();
    logic [31:0] w [4];
    logic [31:0] mask;
    logic [31:0] data;
    logic [31:0] d;
    int          start;
    int          i;
    start = errors;
    for (i = 0; i < 4; i++)
    begin
        rand_word(w[i]);
        write_csr(14'(`CSR_ADDR_SAVE0 + i), w[i]);
    end
    for (i = 0; i < 4; i++)
    begin
        read_csr(14'(`CSR_ADDR_SAVE0 + i), d);
        check_word($sformatf("save%0d", i), d, w[i]);
    end
    rand_word(mask);
    rand_word(data);
    send(op_xchg, csr_arg(`CSR_ADDR_SAVE0), data, mask, base_pc, 32'h0);
    check_word("xchg rdata", rdata, w[0]);
    @(posedge clk);
    @(negedge clk);
    read_csr(`CSR_ADDR_SAVE0, d);
    check_word("save0 bits with mask 0", d & ~mask, w[0] & ~mask);
    check_word("save0 bits with mask 1", d & mask, data & mask);
    // DA and PG both set is ignored
    write_csr(`CSR_ADDR_CRMD, 32'h18);
    read_csr(`CSR_ADDR_CRMD, d);
    check_word("crmd da/pg", d, 32'h8);
    end_test("masked writes", start);
endtask

task automatic test_excp_entry();
    logic [31:0] entry;
    logic [31:0] pc;
    logic [31:0] va;
    logic [31:0] pc2;
    logic [31:0] va2;
    logic [31:0] d;
    int          start;
    start = errors;
    rand_word(entry);
    entry[5:0] = 6'h0;
    rand_word(pc);
    pc[1:0] = 2'b0;
    rand_word(va);
    write_csr(`CSR_ADDR_EENTRY, entry);
    write_csr(`CSR_ADDR_CRMD, 32'hb);    // plv3 with da set
    send(op_excp, excp_arg(`CSR_ECODE_ALE, 9'h0), 32'h0, 32'h0, pc, va);
    check_resp("ale resp", resp, make_resp(1'b1, entry, 1'b0));
    wait_flag("excp_flush");
    read_csr(`CSR_ADDR_ERA, d);
    check_word("era", d, pc);
    read_csr(`CSR_ADDR_BADV, d);
    check_word("badv", d, va);
    read_csr(`CSR_ADDR_PRMD, d);
    check_word("prmd", d, 32'h3);
    read_csr(`CSR_ADDR_CRMD, d);
    check_word("crmd", d, 32'h8);
    check_word("ecode port", {26'b0, ecode}, {26'b0, `CSR_ECODE_ALE});
    // syscall carries no address
    rand_word(pc2);
    pc2[1:0] = 2'b0;
    rand_word(va2);
    send(op_excp, excp_arg(`CSR_ECODE_SYS, 9'h0), 32'h0, 32'h0, pc2, va2);
    check_resp("sys resp", resp, make_resp(1'b1, entry, 1'b0));
    wait_flag("excp_flush");
    read_csr(`CSR_ADDR_BADV, d);
    check_word("badv after sys", d, va);
    read_csr(`CSR_ADDR_ERA, d);
    check_word("era after sys", d, pc2);
    check_word("ecode port", {26'b0, ecode}, {26'b0, `CSR_ECODE_SYS});
    end_test("exception entry", start);
endtask

task automatic test_ertn();
    logic [31:0] era;
    logic [31:0] d;
    int          start;
    start = errors;
    rand_word(era);
    era[1:0] = 2'b0;
    write_csr(`CSR_ADDR_ERA, era);
    write_csr(`CSR_ADDR_PRMD, 32'h3);    // plv3 with pie clear
    send(op_ertn, csr_arg(14'h0), 32'h0, 32'h0, base_pc, 32'h0);
    check_resp("ertn resp", resp, make_resp(1'b1, era, 1'b0));
    wait_flag("ertn_flush");
    read_csr(`CSR_ADDR_CRMD, d);
    check_word("crmd after ertn", d, 32'h8 | 32'h3);
    end_test("exception return", start);
endtask

task automatic test_timer();
    logic [31:0] d;
    int          start;
    int          n;
    bit          seen;
    start = errors;
    write_csr(`CSR_ADDR_TCFG, 32'h10 | 32'h1);    // one-shot count of 16
    seen = 1'b0;
    for (n = 0; n < 64 && !seen; n++)
    begin
        read_csr(`CSR_ADDR_ESTAT, d);
        seen = d[11];
    end
    if (!seen)
    begin
        $display("timeout: timer interrupt bit never set in ESTAT");
        errors++;
    end
    write_csr(`CSR_ADDR_TICLR, 32'h1);
    read_csr(`CSR_ADDR_ESTAT, d);
    check_word("estat.ti", {31'b0, d[11]}, 32'h0);
    read_csr(`CSR_ADDR_TVAL, d);
    check_word("tval", d, 32'hffff_ffff);
    end_test("timer", start);
endtask

task automatic test_hw_int();
    logic [31:0] entry;
    logic [31:0] d;
    int          start;
    start = errors;
    rand_word(entry);
    entry[5:0] = 6'h0;
    write_csr(`CSR_ADDR_EENTRY, entry);
    write_csr(`CSR_ADDR_ECFG, 32'h4);    // hw line 0
    write_csr(`CSR_ADDR_CRMD, 32'hc);    // ie on at plv0
    hw_int = 8'h01;
    wait_flag("flush");
    check_resp("int resp", resp, make_resp(1'b1, entry, 1'b0));
    hw_int = 8'h00;
    wait_flag("excp_flush");
    check_word("ecode port", {26'b0, ecode}, {26'b0, `CSR_ECODE_INT});
    read_csr(`CSR_ADDR_ESTAT, d);
    check_word("estat.ecode", {26'b0, d[21:16]}, {26'b0, `CSR_ECODE_INT});
    read_csr(`CSR_ADDR_PRMD, d);
    check_word("prmd", d, 32'h4);
    read_csr(`CSR_ADDR_CRMD, d);
    check_word("crmd", d, 32'h8);
    end_test("hardware interrupt", start);
endtask

//--- sim/tb_csr.sv
`include "csr_config.svh"

module tb_csr
    import csr_pkg::*;
();

    localparam logic [31:0] base_pc = 32'h1c00_0100;

    logic        clk;
    logic        rstn;
    csr_req_t    req;
    logic        stall;
    logic        pipe_flush;
    logic [7:0]  hw_int;
    logic        ipi;
    csr_resp_t   resp;
    logic [31:0] rdata;
    logic [8:0]  crmd;
    logic        ertn_flush;
    logic [5:0]  ecode;
    logic [31:0] lfsr;
    int          errors;
    int          tests_run;

    tb_clkgen u_clkgen (
        .clk (clk)
    );

    csr_top dut0 (
        .clk        (clk),
        .rstn       (rstn),
        .req        (req),
        .stall      (stall),
        .pipe_flush (pipe_flush),
        .hw_int     (hw_int),
        .ipi        (ipi),
        .resp       (resp),
        .rdata      (rdata),
        .crmd       (crmd),
        .ertn_flush (ertn_flush),
        .ecode      (ecode)
    );

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_word(output logic [31:0] w);
        int i;
        for (i = 0; i < 32; i++)
        begin
            lfsr = lfsr_step(lfsr);
            w    = {w[30:0], lfsr[0]};
        end
    endtask

    function automatic csr_arg_u csr_arg(input logic [13:0] num);
        csr_arg_u a;
        a         = '0;
        a.csr.num = num;
        return a;
    endfunction

    function automatic csr_arg_u excp_arg(input logic [5:0] code, input logic [8:0] sub);
        csr_arg_u a;
        a               = '0;
        a.excp.ecode    = code;
        a.excp.esubcode = sub;
        return a;
    endfunction

    function automatic csr_resp_t make_resp(input logic flush, input logic [31:0] pc,
                                            input logic excp);
        csr_resp_t r;
        r.flush       = flush;
        r.redirect_pc = pc;
        r.excp_flush  = excp;
        return r;
    endfunction

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_resp(input string name, input csr_resp_t got, input csr_resp_t exp);
        if (got !== exp)
        begin
            $display("mismatch %s: got flush=0x%h redirect_pc=0x%h excp_flush=0x%h",
                     name, got.flush, got.redirect_pc, got.excp_flush);
            $display("    expected flush=0x%h redirect_pc=0x%h excp_flush=0x%h",
                     exp.flush, exp.redirect_pc, exp.excp_flush);
            errors++;
        end
    endtask

    // called on a falling edge, returns on the falling edge after acceptance
    task automatic send(input csr_op_e op, input csr_arg_u arg, input logic [31:0] wdata,
                        input logic [31:0] wmask, input logic [31:0] pc,
                        input logic [31:0] vaddr);
        req.valid = 1'b1;
        req.op    = op;
        req.arg   = arg;
        req.wdata = wdata;
        req.wmask = wmask;
        req.pc    = pc;
        req.vaddr = vaddr;
        @(posedge clk);
        @(negedge clk);
        req = '0;
    endtask

    task automatic read_csr(input logic [13:0] num, output logic [31:0] data);
        send(op_rd, csr_arg(num), 32'h0, 32'h0, base_pc, 32'h0);
        data = rdata;
    endtask

    task automatic write_csr(input logic [13:0] num, input logic [31:0] data);
        send(op_wr, csr_arg(num), data, 32'h0, base_pc, 32'h0);
        check_resp("wr resp", resp, make_resp(1'b1, base_pc + 32'd4, 1'b0));
        @(posedge clk);    // commit edge
        @(negedge clk);
    endtask

    task automatic wait_flag(input string name);
        int  n;
        bit  seen;
        seen = 1'b0;
        for (n = 0; n < 8 && !seen; n++)
        begin
            @(negedge clk);
            if (name == "excp_flush")
                seen = resp.excp_flush;
            else if (name == "ertn_flush")
                seen = ertn_flush;
            else
                seen = resp.flush;
        end
        if (!seen)
        begin
            $display("timeout: %s never went high", name);
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int start);
        tests_run++;
        if (errors == start)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d errors", name, errors - start);
    endtask

`include "tb_csr_tasks.svh"

    initial
    begin
        repeat (5000) @(posedge clk);
        $display("timeout: test sequence did not finish");
        $display("Verification failed");
        $finish;
    end

    initial
    begin
        rstn       = 1'b0;
        req        = '0;
        stall      = 1'b0;
        pipe_flush = 1'b0;
        hw_int     = 8'h0;
        ipi        = 1'b0;
        lfsr       = 32'h7b8a364f;
        errors     = 0;
        tests_run  = 0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        test_reset();
        test_masked_writes();
        test_excp_entry();
        test_ertn();
        test_timer();
        test_hw_int();
        $display("tests run: %0d, errors: %0d", tests_run, errors);
        if (errors == 0)
        begin
            $display("Verification passed");
        end
        else
        begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- sim/tb_clkgen.sv
module tb_clkgen (
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #4 clk = ~clk;    // period 8
        end
    end

endmodule

//--- hdl/csr_top.sv
`include "csr_config.svh"

module csr_top
    import csr_pkg::*;
(
    input  logic                 clk,
    input  logic                 rstn,
    input  csr_req_t             req,
    input  logic                 stall,
    input  logic                 pipe_flush,
    input  logic [7:0]           hw_int,
    input  logic                 ipi,
    output csr_resp_t            resp,
    output logic [`CSR_XLEN-1:0] rdata,
    output logic [8:0]           crmd,
    output logic                 ertn_flush,
    output logic [5:0]           ecode
);

    csr_issue_t                 issue;
    csr_state_t                 state;
    csr_resp_t                  issue_resp;
    logic                       excp_flush;
    logic                       tcfg_we;
    logic                       ticlr_we;
    logic [`CSR_XLEN-1:0]       timer_wdata;
    logic [`CSR_TIMER_BITS-1:0] tcfg;
    logic [`CSR_TIMER_BITS-1:0] tval;
    logic                       ti;

    csr_issue u_issue (
        .clk        (clk),
        .rstn       (rstn),
        .req        (req),
        .stall      (stall),
        .pipe_flush (pipe_flush),
        .hw_int     (hw_int),
        .ipi        (ipi),
        .ti         (ti),
        .state      (state),
        .issue      (issue),
        .resp       (issue_resp),
        .rdata      (rdata)
    );

    csr_regfile u_regfile (
        .clk         (clk),
        .rstn        (rstn),
        .issue       (issue),
        .req_num     (req.arg.csr.num),
        .hw_int      (hw_int),
        .ipi         (ipi),
        .tcfg        (tcfg),
        .tval        (tval),
        .ti          (ti),
        .state       (state),
        .crmd        (crmd),
        .ertn_flush  (ertn_flush),
        .excp_flush  (excp_flush),
        .ecode       (ecode),
        .tcfg_we     (tcfg_we),
        .ticlr_we    (ticlr_we),
        .timer_wdata (timer_wdata)
    );

    csr_timer u_timer (
        .clk      (clk),
        .rstn     (rstn),
        .tcfg_we  (tcfg_we),
        .ticlr_we (ticlr_we),
        .wdata    (timer_wdata),
        .tcfg     (tcfg),
        .tval     (tval),
        .ti       (ti)
    );

    // excp_flush comes from the commit stage, one cycle after the redirect
    assign resp = '{flush:       issue_resp.flush,
                    redirect_pc: issue_resp.redirect_pc,
                    excp_flush:  excp_flush};

endmodule

//--- hdl/csr_timer.sv
`include "csr_config.svh"

module csr_timer (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       tcfg_we,
    input  logic                       ticlr_we,
    input  logic [`CSR_XLEN-1:0]       wdata,
    output logic [`CSR_TIMER_BITS-1:0] tcfg,
    output logic [`CSR_TIMER_BITS-1:0] tval,
    output logic                       ti
);

    logic en_q;     // enable bit one cycle late, for edge detect
    logic en;
    logic periodic;
    logic en_rise;
    logic en_fall;

    assign en       = tcfg[0];
    assign periodic = tcfg[1];
    assign en_rise  = en && !en_q;
    assign en_fall  = !en && en_q;

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            tcfg <= '0;
            tval <= '0;
            en_q <= 1'b0;
            ti   <= 1'b0;
        end
        else
        begin
            en_q <= en;
            if (tcfg_we)
            begin
                tcfg <= wdata[`CSR_TIMER_BITS-1:0];
            end

            if (ticlr_we)
            begin
                ti <= 1'b0;
            end
            else if (tval == '0 && en && en_q)
            begin
                ti <= 1'b1;
            end

            // one-shot wraps to all ones and stops there
            if (en_rise || (tval == '0 && periodic && en))
            begin
                tval <= {tcfg[`CSR_TIMER_BITS-1:2], 2'b0};
            end
            else if (en_fall)
            begin
                tval <= '0;
            end
            else if (en && tval != '1)
            begin
                tval <= tval - 1'b1;
            end
        end
    end

endmodule

//--- hdl/csr_regfile.sv
`include "csr_config.svh"

module csr_regfile
    import csr_pkg::*;
(
    input  logic                       clk,
    input  logic                       rstn,
    input  csr_issue_t                 issue,
    input  logic [13:0]                req_num,
    input  logic [7:0]                 hw_int,
    input  logic                       ipi,
    input  logic [`CSR_TIMER_BITS-1:0] tcfg,
    input  logic [`CSR_TIMER_BITS-1:0] tval,
    input  logic                       ti,
    output csr_state_t                 state,
    output logic [8:0]                 crmd,
    output logic                       ertn_flush,
    output logic                       excp_flush,
    output logic [5:0]                 ecode,
    output logic                       tcfg_we,
    output logic                       ticlr_we,
    output logic [`CSR_XLEN-1:0]       timer_wdata
);

    logic [2:0]           prmd;
    logic [12:0]          ecfg_lie;
    logic [1:0]           estat_is;
    logic [8:0]           estat_esub;
    logic [`CSR_XLEN-1:0] era;
    logic [`CSR_XLEN-1:0] badv;
    logic [`CSR_XLEN-1:6] eentry;
    logic [`CSR_XLEN-1:0] save0;
    logic [`CSR_XLEN-1:0] save1;
    logic [`CSR_XLEN-1:0] save2;
    logic [`CSR_XLEN-1:0] save3;
    logic [`CSR_XLEN-1:0] tid;
    logic [`CSR_XLEN-1:0] estat_word;
    logic [`CSR_XLEN-1:0] rdata;
    logic [`CSR_XLEN-1:0] wdata;
    logic [13:0]          wr_num;
    logic                 wr_commit;
    logic                 badv_load;

    assign wdata     = issue.wdata;
    assign wr_num    = issue.arg.csr.num;
    assign wr_commit = issue.valid && (issue.op == op_wr || issue.op == op_xchg);

    // timer registers live in csr_timer
    assign tcfg_we     = wr_commit && (wr_num == `CSR_ADDR_TCFG);
    assign ticlr_we    = wr_commit && (wr_num == `CSR_ADDR_TICLR) && wdata[0];
    assign timer_wdata = wdata;

    // IS[12:2] reflect the live lines
    assign estat_word = {1'b0, estat_esub, ecode, 3'b0, ipi, ti, 1'b0, hw_int, estat_is};

    always_comb
    begin
        case (req_num)
            `CSR_ADDR_CRMD:   rdata = {23'b0, crmd};
            `CSR_ADDR_PRMD:   rdata = {29'b0, prmd};
            `CSR_ADDR_ECFG:   rdata = {19'b0, ecfg_lie};
            `CSR_ADDR_ESTAT:  rdata = estat_word;
            `CSR_ADDR_ERA:    rdata = era;
            `CSR_ADDR_BADV:   rdata = badv;
            `CSR_ADDR_EENTRY: rdata = {eentry, 6'b0};
            `CSR_ADDR_SAVE0:  rdata = save0;
            `CSR_ADDR_SAVE1:  rdata = save1;
            `CSR_ADDR_SAVE2:  rdata = save2;
            `CSR_ADDR_SAVE3:  rdata = save3;
            `CSR_ADDR_TID:    rdata = tid;
            `CSR_ADDR_TCFG:   rdata = tcfg;
            `CSR_ADDR_TVAL:   rdata = tval;
            default:          rdata = '0;    // TICLR reads as zero
        endcase
    end

    always_comb
    begin
        state.crmd_ie  = crmd[2];
        state.crmd_lo  = crmd[2:0];
        state.ecfg_lie = ecfg_lie;
        state.estat_is = estat_is;
        state.era      = era;
        state.eentry   = {eentry, 6'b0};
        state.rdata    = rdata;
    end

    // causes that carry a faulting address
    always_comb
    begin
        case (issue.arg.excp.ecode)
            `CSR_ECODE_ALE, `CSR_ECODE_PIL, `CSR_ECODE_PIS,
            `CSR_ECODE_PIF, `CSR_ECODE_PME, `CSR_ECODE_PPI:
                badv_load = 1'b1;
            `CSR_ECODE_ADE:
                badv_load = (issue.arg.excp.esubcode == `CSR_ESUB_ADEF);
            default:
                badv_load = 1'b0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            crmd       <= `CSR_CRMD_RESET;
            prmd       <= '0;
            ecfg_lie   <= '0;
            estat_is   <= '0;
            ecode      <= '0;
            estat_esub <= '0;
            era        <= '0;
            badv       <= '0;
            eentry     <= '0;
            save0      <= '0;
            save1      <= '0;
            save2      <= '0;
            save3      <= '0;
            tid        <= '0;
            excp_flush <= 1'b0;
            ertn_flush <= 1'b0;
        end
        else
        begin
            excp_flush <= 1'b0;
            ertn_flush <= 1'b0;
            if (issue.valid)
            begin
                case (issue.op)
                    op_wr, op_xchg:
                    begin
                        case (wr_num)
                            `CSR_ADDR_CRMD:
                            begin
                                crmd[2:0] <= wdata[2:0];
                                crmd[8:5] <= wdata[8:5];
                                if (wdata[4] ^ wdata[3])    // DA and PG never both set
                                begin
                                    crmd[4:3] <= wdata[4:3];
                                end
                            end
                            `CSR_ADDR_PRMD:   prmd     <= wdata[2:0];
                            `CSR_ADDR_ECFG:   ecfg_lie <= {wdata[12:11], 1'b0, wdata[9:0]};
                            `CSR_ADDR_ESTAT:  estat_is <= wdata[1:0];   // software bits only
                            `CSR_ADDR_ERA:    era      <= wdata;
                            `CSR_ADDR_BADV:   badv     <= wdata;
                            `CSR_ADDR_EENTRY: eentry   <= wdata[`CSR_XLEN-1:6];
                            `CSR_ADDR_SAVE0:  save0    <= wdata;
                            `CSR_ADDR_SAVE1:  save1    <= wdata;
                            `CSR_ADDR_SAVE2:  save2    <= wdata;
                            `CSR_ADDR_SAVE3:  save3    <= wdata;
                            `CSR_ADDR_TID:    tid      <= wdata;
                            default:          ;
                        endcase
                    end
                    op_excp:
                    begin
                        prmd       <= crmd[2:0];
                        crmd[2:0]  <= 3'b0;    // plv0, interrupts off
                        era        <= issue.pc;
                        ecode      <= issue.arg.excp.ecode;
                        estat_esub <= issue.arg.excp.esubcode;
                        excp_flush <= 1'b1;
                        if (badv_load)
                        begin
                            badv <= issue.vaddr;
                        end
                    end
                    op_ertn:
                    begin
                        crmd[2:0]  <= prmd;
                        ertn_flush <= 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

//--- hdl/csr_issue.sv
`include "csr_config.svh"

module csr_issue
    import csr_pkg::*;
(
    input  logic                 clk,
    input  logic                 rstn,
    input  csr_req_t             req,
    input  logic                 stall,
    input  logic                 pipe_flush,
    input  logic [7:0]           hw_int,
    input  logic                 ipi,
    input  logic                 ti,
    input  csr_state_t           state,
    output csr_issue_t           issue,
    output csr_resp_t            resp,
    output logic [`CSR_XLEN-1:0] rdata
);

    logic [12:0]          int_vec;
    logic                 excp_busy;
    logic                 take_int;
    logic                 accept;
    logic [`CSR_XLEN-1:0] merge_mask;
    logic [`CSR_XLEN-1:0] redirect;
    logic                 flush;
    csr_issue_t           word;

    // same bit layout as ECFG.LIE, bit 10 has no source
    assign int_vec = {ipi, ti, 1'b0, hw_int, state.estat_is} & state.ecfg_lie;

    // an entry in the issue register has not cleared CRMD.IE yet
    assign excp_busy = issue.valid && (issue.op == op_excp);
    assign take_int  = (|int_vec) && state.crmd_ie && !excp_busy;
    assign accept    = !stall && !pipe_flush;

    always_comb
    begin
        merge_mask = (req.op == op_xchg) ? req.wmask : '1;
        word.valid = req.valid;
        word.op    = req.op;
        word.arg   = req.arg;
        word.wdata = (state.rdata & ~merge_mask) | (req.wdata & merge_mask);
        word.pc    = req.pc;
        word.vaddr = req.vaddr;
        if (take_int)
        begin
            word.valid          = 1'b1;
            word.op             = op_excp;
            word.arg            = '0;
            word.arg.excp.ecode = `CSR_ECODE_INT;
        end
        // fetch address error reports the pc itself
        if (word.op == op_excp && word.arg.excp.ecode == `CSR_ECODE_ADE
            && word.arg.excp.esubcode == `CSR_ESUB_ADEF)
        begin
            word.vaddr = word.pc;
        end
    end

    always_comb
    begin
        redirect = word.pc + 32'd4;
        flush    = 1'b0;
        case (word.op)
            op_excp:
            begin
                redirect = state.eentry;
                flush    = 1'b1;
            end
            op_ertn:
            begin
                redirect = state.era;
                flush    = 1'b1;
            end
            op_wr, op_xchg:
                flush = 1'b1;
            default:
                flush = 1'b0;
        endcase
        flush = flush && word.valid;
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            issue.valid     <= 1'b0;
            resp.flush      <= 1'b0;
            resp.excp_flush <= 1'b0;
        end
        else if (take_int || accept)
        begin
            issue            <= word;
            resp.flush       <= flush;
            resp.redirect_pc <= redirect;
            resp.excp_flush  <= word.valid && (word.op == op_excp);
            rdata            <= state.rdata;
        end
        else
        begin
            // stalled or flushed, keep the payload but commit only once
            issue.valid     <= 1'b0;
            resp.flush      <= 1'b0;
            resp.excp_flush <= 1'b0;
        end
    end

endmodule

//--- hdl/csr_pkg.sv
`include "csr_config.svh"

package csr_pkg;

    typedef enum logic [2:0] {
        op_none,
        op_rd,
        op_wr,
        op_xchg,
        op_ertn,
        op_excp
    } csr_op_e;

    // one argument word, csr number or exception cause
    typedef union packed {
        struct packed {
            logic [1:0]  rsvd;
            logic [13:0] num;
        } csr;
        struct packed {
            logic        rsvd;
            logic [8:0]  esubcode;
            logic [5:0]  ecode;
        } excp;
    } csr_arg_u;

    typedef struct packed {
        logic                 valid;
        csr_op_e              op;
        csr_arg_u             arg;
        logic [`CSR_XLEN-1:0] wdata;
        logic [`CSR_XLEN-1:0] wmask;    // xchg only
        logic [`CSR_XLEN-1:0] pc;
        logic [`CSR_XLEN-1:0] vaddr;
    } csr_req_t;

    typedef struct packed {
        logic                 valid;
        csr_op_e              op;
        csr_arg_u             arg;
        logic [`CSR_XLEN-1:0] wdata;    // already merged under the mask
        logic [`CSR_XLEN-1:0] pc;
        logic [`CSR_XLEN-1:0] vaddr;
    } csr_issue_t;

    typedef struct packed {
        logic                 crmd_ie;
        logic [2:0]           crmd_lo;
        logic [12:0]          ecfg_lie;
        logic [1:0]           estat_is;
        logic [`CSR_XLEN-1:0] era;
        logic [`CSR_XLEN-1:0] eentry;
        logic [`CSR_XLEN-1:0] rdata;    // for the csr number of the incoming request
    } csr_state_t;

    typedef struct packed {
        logic                 flush;
        logic [`CSR_XLEN-1:0] redirect_pc;
        logic                 excp_flush;
    } csr_resp_t;

endpackage

//--- hdl/csr_config.svh
`ifndef CSR_CONFIG_SVH
`define CSR_CONFIG_SVH

`define CSR_XLEN        32
`define CSR_TIMER_BITS  32

// csr numbers
`define CSR_ADDR_CRMD   14'h0
`define CSR_ADDR_PRMD   14'h1
`define CSR_ADDR_ECFG   14'h4
`define CSR_ADDR_ESTAT  14'h5
`define CSR_ADDR_ERA    14'h6
`define CSR_ADDR_BADV   14'h7
`define CSR_ADDR_EENTRY 14'hc
`define CSR_ADDR_SAVE0  14'h30
`define CSR_ADDR_SAVE1  14'h31
`define CSR_ADDR_SAVE2  14'h32
`define CSR_ADDR_SAVE3  14'h33
`define CSR_ADDR_TID    14'h40
`define CSR_ADDR_TCFG   14'h41
`define CSR_ADDR_TVAL   14'h42
`define CSR_ADDR_TICLR  14'h44

`define CSR_ECODE_INT   6'h0
`define CSR_ECODE_PIL   6'h1
`define CSR_ECODE_PIS   6'h2
`define CSR_ECODE_PIF   6'h3
`define CSR_ECODE_PME   6'h4
`define CSR_ECODE_PPI   6'h7
`define CSR_ECODE_ADE   6'h8
`define CSR_ECODE_ALE   6'h9
`define CSR_ECODE_SYS   6'hb
`define CSR_ECODE_BRK   6'hc
`define CSR_ECODE_INE   6'hd

`define CSR_ESUB_ADEF   9'h0

`define CSR_CRMD_RESET  9'h8    // DA=1, direct address mode

`endif
